// File: all.f
mips_exec_pkg.sv
alu_op_if.sv
exec_wb_if.sv
host_if.sv
mips_apb_port.sv
mips_decode.sv
mips_alu.sv
mips_writeback.sv
mips_exec_unit.sv
tb_clkgen.sv
tb_mips_exec.sv

// File: Makefile
TOP = tb_mips_exec

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f all.f -o sim

run: compile
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	grep -qF "*** TEST PASSED ***" sim.log

clean:
	rm -rf obj_dir sim.log

// File: tb_mips_exec.sv
`timescale 1ns/100ps

module tb_mips_exec
    import mips_exec_pkg::*;
();
    // About 140 instructions at near 21 cycles each plus a few full register sweeps
    localparam int TIMEOUT_CYCLES = 6000;

    logic        clk;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [31:0] shadow_gpr [0:31];
    logic [31:0] exp_result;
    logic [1:0]  exp_status;
    logic [31:0] exp_pc;
    int          seed = 32'h515e_4cf8;
    int          cycles = 0;

    tb_clkgen #(.PERIOD(20), .RST_CYCLES(8)) clkgen0 (.o_clk(clk), .o_rst(rst));

    mips_exec_unit #(
        .APB_ADDR_W(12)
    ) dut0 (
        .i_clk(clk),
        .i_rst(rst),
        .i_psel(psel),
        .i_penable(penable),
        .i_pwrite(pwrite),
        .i_paddr(paddr),
        .i_pwdata(pwdata),
        .o_prdata(prdata),
        .o_pready(pready),
        .o_pslverr(pslverr)
    );

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the DUT stopped answering APB accesses", cycles);
            $display("*** TEST FAILED ***");
            $fatal(1, "Simulation timed out");
        end
    end

    function automatic logic [31:0] next_rand();
        return $random(seed);
    endfunction

    function automatic logic [4:0] pick_reg();
        return 5'(next_rand() % 31) + 5'd1; // Never r0
    endfunction

    function automatic logic [31:0] r_type_word(input logic [5:0] fn, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [4:0] rd,
                                                input logic [4:0] sa);
        return {6'h00, rs, rt, rd, sa, fn};
    endfunction

    function automatic logic [31:0] i_type_word(input logic [5:0] opc, input logic [4:0] rs,
                                                input logic [4:0] rt, input logic [15:0] imm);
        return {opc, rs, rt, imm};
    endfunction

    function automatic logic add_overflows(input logic [31:0] a, input logic [31:0] b,
                                           input logic [31:0] sum);
        return (a[31] == b[31]) && (sum[31] != a[31]);
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("CHECK FAILED at %0d ns: %s is %08h, expected %08h", $time, name, got, exp);
            $display("*** TEST FAILED ***");
            $fatal(1, "Check on %s failed", name);
        end
    endtask

    task automatic apb_transfer(input logic write, input logic [11:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = write;
        paddr   = addr;
        pwdata  = wdata;
        @(negedge clk);
        penable = 1'b1;
        #5;
        while (!pready) begin // Wait states while an instruction is in flight
            @(negedge clk);
            #5;
        end
        rdata = prdata;
        err   = pslverr;
        @(posedge clk);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [11:0] addr, input logic [31:0] data,
                             input logic exp_err);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b1, addr, data, rdata, err);
        expect_equal("PSLVERR", {31'b0, err}, {31'b0, exp_err});
    endtask

    task automatic apb_read(input logic [11:0] addr, input logic [31:0] exp_data,
                            input logic exp_err, input string name);
        logic [31:0] rdata;
        logic        err;
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
        expect_equal("PSLVERR", {31'b0, err}, {31'b0, exp_err});
        if (!exp_err)
            expect_equal(name, rdata, exp_data);
    endtask

    task automatic set_gpr(input logic [4:0] idx, input logic [31:0] value);
        apb_write(REG_GPR_BASE + 12'({idx, 2'b00}), value, 1'b0);
        if (idx != 5'd0)
            shadow_gpr[idx] = value;
    endtask

    task automatic verify_gpr(input logic [4:0] idx);
        apb_read(REG_GPR_BASE + 12'({idx, 2'b00}), shadow_gpr[idx], 1'b0,
                 $sformatf("GPR r%0d", idx));
    endtask

    task automatic verify_all_gprs();
        for (int i = 0; i < 32; i++) begin
            verify_gpr(5'(i));
        end
    endtask

    task automatic result_and_status_match();
        apb_read(REG_RESULT, exp_result, 1'b0, "RESULT");
        apb_read(REG_STATUS, {30'b0, exp_status}, 1'b0, "STATUS");
    endtask

    // Reference model of one instruction on the shadow state
    task automatic model_instr(input logic [31:0] ins);
        logic [5:0]  opc;
        logic [5:0]  fn;
        logic [4:0]  rt;
        logic [4:0]  dst;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] simm;
        logic [31:0] zimm;
        logic [31:0] res;
        logic        ovf;
        logic        ill;
        logic        writes;
        opc    = ins[31:26];
        fn     = ins[5:0];
        rt     = ins[20:16];
        a      = shadow_gpr[ins[25:21]];
        b      = shadow_gpr[rt];
        simm   = {{16{ins[15]}}, ins[15:0]};
        zimm   = {16'h0000, ins[15:0]};
        dst    = (opc == 6'h00) ? ins[15:11] : rt;
        res    = 32'h0;
        ovf    = 1'b0;
        ill    = 1'b0;
        writes = 1'b1;
        case (opc)
            6'h00: begin
                case (fn)
                    6'h00: res = b << ins[10:6];
                    6'h02: res = b >> ins[10:6];
                    6'h03: res = $signed(b) >>> ins[10:6];
                    6'h04: res = b << a[4:0];
                    6'h06: res = b >> a[4:0];
                    6'h07: res = $signed(b) >>> a[4:0];
                    6'h09: res = exp_pc + 32'd8;
                    6'h20, 6'h21: begin
                        res = a + b;
                        ovf = (fn == 6'h20) && add_overflows(a, b, res);
                    end
                    6'h22, 6'h23: begin
                        res = a - b;
                        ovf = (fn == 6'h22) && (a[31] != b[31]) && (res[31] != a[31]);
                    end
                    6'h24: res = a & b;
                    6'h25: res = a | b;
                    6'h26: res = a ^ b;
                    6'h27: res = ~(a | b);
                    6'h2A: res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    6'h2B: res = (a < b) ? 32'd1 : 32'd0;
                    default: ill = 1'b1;
                endcase
            end
            6'h01, 6'h03: begin // Links happen whether or not a branch would be taken
                dst = 5'd31;
                res = exp_pc + 32'd8;
                ill = (opc == 6'h01) && !(rt == 5'h10 || rt == 5'h11);
            end
            6'h08, 6'h09: begin
                res = a + simm;
                ovf = (opc == 6'h08) && add_overflows(a, simm, res);
            end
            6'h0A: res = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
            6'h0B: res = (a < simm) ? 32'd1 : 32'd0;
            6'h0C: res = a & zimm;
            6'h0D: res = a | zimm;
            6'h0E: res = a ^ zimm;
            6'h0F: res = {ins[15:0], 16'h0000};
            6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
            6'h28, 6'h29, 6'h2A, 6'h2B, 6'h2E: begin
                res    = a + simm; // Effective address only
                writes = 1'b0;
            end
            default: ill = 1'b1;
        endcase
        if (ill)
            exp_status[STAT_ILL] = 1'b1;
        else
            exp_result = res;
        if (ovf)
            exp_status[STAT_OVF] = 1'b1;
        else if (!ill && writes && dst != 5'd0)
            shadow_gpr[dst] = res;
    endtask

    task automatic execute_and_check(input logic [31:0] ins);
        apb_write(REG_INSTR, ins, 1'b0);
        model_instr(ins);
        result_and_status_match();
        verify_gpr(ins[20:16]);
        verify_gpr(ins[15:11]);
    endtask

    task automatic sweep_gprs();
        for (int i = 0; i < 32; i++) begin
            set_gpr(5'(i), next_rand());
        end
        verify_all_gprs();
    endtask

    task automatic rtype_ops();
        logic [5:0] functs [0:7];
        logic [4:0] rs;
        logic [4:0] rt;
        functs = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26, 6'h27};
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 5; k++) begin
                rs = pick_reg();
                rt = pick_reg();
                set_gpr(rs, next_rand());
                set_gpr(rt, next_rand());
                execute_and_check(r_type_word(functs[f], rs, rt, pick_reg(), 5'd0));
            end
        end
    endtask

    task automatic immediate_and_shift_ops();
        logic [5:0] functs [0:7];
        logic [4:0] rs;
        logic [4:0] rt;
        functs = '{6'h00, 6'h02, 6'h03, 6'h04, 6'h06, 6'h07, 6'h2A, 6'h2B};
        for (int op = 8; op < 16; op++) begin
            for (int k = 0; k < 4; k++) begin
                rs = pick_reg();
                set_gpr(rs, next_rand());
                execute_and_check(i_type_word(6'(op), rs, pick_reg(), 16'(next_rand())));
            end
        end
        for (int f = 0; f < 8; f++) begin
            for (int k = 0; k < 4; k++) begin
                rs = pick_reg();
                rt = pick_reg();
                set_gpr(rs, next_rand());
                set_gpr(rt, next_rand());
                execute_and_check(r_type_word(functs[f], rs, rt, pick_reg(),
                                              5'(next_rand())));
            end
        end
    endtask

    task automatic overflow_cases();
        logic [4:0] rs;
        logic [4:0] rt;
        for (int k = 0; k < 3; k++) begin
            rs = pick_reg();
            rt = (rs == 5'd31) ? 5'd1 : rs + 5'd1;
            set_gpr(rs, {2'b01, 30'(next_rand())});
            set_gpr(rt, {2'b01, 30'(next_rand())});
            execute_and_check(r_type_word(6'h20, rs, rt, pick_reg(), 5'd0));
            set_gpr(rt, {2'b10, 30'(next_rand())});
            execute_and_check(r_type_word(6'h22, rs, rt, pick_reg(), 5'd0));
            set_gpr(rs, {24'h7FFFFF, 8'(next_rand())});
            execute_and_check(i_type_word(6'h08, rs, rt, {8'h01, 8'(next_rand())}));
            apb_write(REG_STATUS, 32'h1, 1'b0);
            exp_status[STAT_OVF] = 1'b0;
            apb_read(REG_STATUS, {30'b0, exp_status}, 1'b0, "STATUS");
        end
    endtask

    task automatic link_ops();
        logic [4:0] rs;
        for (int k = 0; k < 2; k++) begin
            exp_pc = next_rand() & 32'hFFFF_FFFC;
            apb_write(REG_PC, exp_pc, 1'b0);
            apb_read(REG_PC, exp_pc, 1'b0, "PC");
            execute_and_check({6'h03, 26'(next_rand())});
            verify_gpr(5'd31);
            rs = pick_reg();
            set_gpr(rs, next_rand());
            set_gpr(5'd31, next_rand());
            execute_and_check(i_type_word(6'h01, rs, 5'h11, 16'(next_rand())));
            verify_gpr(5'd31);
            set_gpr(5'd31, next_rand());
            execute_and_check(i_type_word(6'h01, rs, 5'h10, 16'(next_rand())));
            verify_gpr(5'd31);
            execute_and_check(r_type_word(6'h09, rs, 5'd0, pick_reg(), 5'd0));
        end
    endtask

    task automatic address_ops();
        logic [5:0] opcs [0:11];
        logic [4:0] rs;
        opcs = '{6'h20, 6'h24, 6'h21, 6'h25, 6'h23, 6'h22, 6'h26,
                 6'h28, 6'h29, 6'h2B, 6'h2A, 6'h2E};
        for (int i = 0; i < 12; i++) begin
            rs = pick_reg();
            set_gpr(rs, next_rand());
            execute_and_check(i_type_word(opcs[i], rs, pick_reg(), 16'(next_rand())));
        end
        verify_all_gprs();
    endtask

    task automatic illegal_ops();
        execute_and_check({6'h3F, 26'(next_rand())});
        execute_and_check({6'h10, 26'(next_rand())});
        execute_and_check(r_type_word(6'h18, pick_reg(), pick_reg(), pick_reg(), 5'd0));
        execute_and_check(i_type_word(6'h01, pick_reg(), 5'h00, 16'(next_rand())));
        verify_all_gprs();
        apb_write(REG_STATUS, 32'h2, 1'b0);
        exp_status[STAT_ILL] = 1'b0;
        apb_read(REG_STATUS, {30'b0, exp_status}, 1'b0, "STATUS");
    endtask

    task automatic bus_errors();
        apb_write(12'h090, next_rand(), 1'b1);
        apb_read(12'h090, 32'h0, 1'b1, "PRDATA");
        apb_read(12'h006, 32'h0, 1'b1, "PRDATA"); // Misaligned and therefore not a GPR
        apb_write(12'h800, next_rand(), 1'b1);
        apb_write(REG_RESULT, next_rand(), 1'b1);
        apb_read(REG_INSTR, 32'h0, 1'b1, "PRDATA");
        result_and_status_match();
        apb_read(REG_PC, exp_pc, 1'b0, "PC");
    endtask

    initial begin
        psel       = 1'b0;
        penable    = 1'b0;
        pwrite     = 1'b0;
        paddr      = 12'h000;
        pwdata     = 32'h0;
        exp_result = 32'h0;
        exp_status = 2'b00;
        exp_pc     = 32'h0;
        for (int i = 0; i < 32; i++) begin
            shadow_gpr[i] = 32'h0;
        end
        wait (!rst);
        result_and_status_match();
        apb_read(REG_PC, exp_pc, 1'b0, "PC");
        verify_all_gprs();
        sweep_gprs();
        rtype_ops();
        immediate_and_shift_ops();
        overflow_cases();
        link_ops();
        address_ops();
        illegal_ops();
        bus_errors();
        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

// File: tb_clkgen.sv
`timescale 1ns/100ps

module tb_clkgen #(
    parameter int PERIOD     = 20,
    parameter int RST_CYCLES = 8
) (
    output logic o_clk,
    output logic o_rst
);
    initial begin
        o_clk = 1'b0;
        forever #(PERIOD / 2) o_clk = ~o_clk;
    end

    initial begin
        o_rst = 1'b1;
        repeat (RST_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b0; // Released between edges so the first active edge sees it low
    end

endmodule

// File: mips_exec_unit.sv
`timescale 1ns/100ps

module mips_exec_unit #(
    parameter int APB_ADDR_W = 12
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [APB_ADDR_W-1:0] i_paddr,
    input  logic [31:0]           i_pwdata,
    output logic [31:0]           o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr
);
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] pc;

    alu_op_if  alu_op_bus ();
    exec_wb_if exec_wb_bus ();
    host_if    host_bus ();

    mips_apb_port #(
        .APB_ADDR_W(APB_ADDR_W)
    ) apb_port0 (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_psel(i_psel),
        .i_penable(i_penable),
        .i_pwrite(i_pwrite),
        .i_paddr(i_paddr),
        .i_pwdata(i_pwdata),
        .o_prdata(o_prdata),
        .o_pready(o_pready),
        .o_pslverr(o_pslverr),
        .o_instr_valid(instr_valid),
        .o_instr(instr),
        .o_pc(pc),
        .dec(alu_op_bus.monitor),
        .exe(exec_wb_bus.monitor),
        .host(host_bus.host)
    );

    mips_decode decode0 (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .i_instr_valid(instr_valid),
        .i_instr(instr),
        .i_pc(pc),
        .alu(alu_op_bus.decode)
    );

    mips_alu alu0 (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .dec(alu_op_bus.execute),
        .wb(exec_wb_bus.execute)
    );

    mips_writeback writeback0 (
        .i_clk(i_clk),
        .i_rst(i_rst),
        .wb(exec_wb_bus.writeback),
        .host(host_bus.target)
    );

endmodule

// File: mips_writeback.sv
`timescale 1ns/100ps

module mips_writeback
    import mips_exec_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_rst,
    exec_wb_if.writeback wb,
    host_if.target       host
);
    logic [31:0] gpr [1:31]; // r0 is not stored
    logic [31:0] result_q;
    logic [1:0]  status_q;
    logic        exe_wr;
    logic        rf_we;
    logic [4:0]  rf_waddr;
    logic [31:0] rf_wdata;

    assign exe_wr   = wb.valid && wb.we && (wb.dest != 5'd0);
    assign rf_we    = exe_wr || (host.gpr_we && (host.gpr_addr != 5'd0));
    assign rf_waddr = exe_wr ? wb.dest : host.gpr_addr; // Execute wins over the host
    assign rf_wdata = exe_wr ? wb.result : host.wdata;

    assign wb.rs_data     = (wb.rs_addr == 5'd0) ? '0 : gpr[wb.rs_addr];
    assign wb.rt_data     = (wb.rt_addr == 5'd0) ? '0 : gpr[wb.rt_addr];
    assign host.gpr_rdata = (host.gpr_addr == 5'd0) ? '0 : gpr[host.gpr_addr];
    assign host.result    = result_q;
    assign host.status    = status_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            for (int i = 1; i < 32; i++) begin
                gpr[i] <= '0;
            end
        end else if (rf_we) begin
            gpr[rf_waddr] <= rf_wdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            result_q <= '0;
            status_q <= '0;
        end else begin
            if (wb.valid && !wb.ill)
                result_q <= wb.result; // Overflowing results still land here
            status_q <= status_q & ~host.stat_clr;
            if (wb.valid && wb.ovf)
                status_q[STAT_OVF] <= 1'b1;
            if (wb.valid && wb.ill)
                status_q[STAT_ILL] <= 1'b1;
        end
    end

    a_no_write_collision: assert property (@(posedge i_clk) disable iff (i_rst)
        exe_wr |-> !host.gpr_we);

endmodule

// File: mips_alu.sv
`timescale 1ns/100ps

module mips_alu
    import mips_exec_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_rst,
    alu_op_if.execute  dec,
    exec_wb_if.execute wb
);
    logic [31:0] srca;
    logic [31:0] srcb;
    logic [31:0] imm32;
    logic [31:0] opb;
    logic [32:0] add_tmp;
    logic [32:0] sub_tmp;
    logic        add_o;
    logic        sub_o;
    logic [4:0]  sh;
    logic [31:0] result_d;
    logic        ovf_d;
    logic        ill_d;

    assign wb.rs_addr = dec.rs; // Register file is read while decode is valid
    assign wb.rt_addr = dec.rt;
    assign srca       = wb.rs_data;
    assign srcb       = wb.rt_data;

    always_comb begin
        case (dec.op)
            OP_ANDI, OP_ORI, OP_XORI: imm32 = {16'b0, dec.imm16};
            OP_LUI:                   imm32 = {dec.imm16, 16'b0};
            default:                  imm32 = {{16{dec.imm16[15]}}, dec.imm16};
        endcase
    end

    assign opb = (dec.op inside {OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI,
                                 OP_XORI, OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL,
                                 OP_LWR, OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR}) ? imm32 : srcb;

    assign add_tmp = {srca[31], srca} + {opb[31], opb};
    assign sub_tmp = {srca[31], srca} - {opb[31], opb};
    assign add_o   = add_tmp[32] != add_tmp[31];
    assign sub_o   = sub_tmp[32] != sub_tmp[31];
    assign sh      = (dec.op inside {OP_SLL, OP_SRL, OP_SRA}) ? dec.shamt : srca[4:0];

    always_comb begin
        case (dec.op)
            OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU,
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
            OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR:
                result_d = add_tmp[31:0];
            OP_SUB, OP_SUBU:           result_d = sub_tmp[31:0];
            OP_AND, OP_ANDI:           result_d = srca & opb;
            OP_OR, OP_ORI:             result_d = srca | opb;
            OP_XOR, OP_XORI:           result_d = srca ^ opb;
            OP_NOR:                    result_d = ~(srca | opb);
            OP_LUI:                    result_d = imm32;
            OP_SLL, OP_SLLV:           result_d = srcb << sh;
            OP_SRL, OP_SRLV:           result_d = srcb >> sh;
            OP_SRA, OP_SRAV:           result_d = 32'($signed(srcb) >>> sh);
            OP_SLT, OP_SLTI:           result_d = {31'b0, $signed(srca) < $signed(opb)};
            OP_SLTU, OP_SLTIU:         result_d = {31'b0, srca < opb};
            OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL:
                result_d = dec.pc + 32'd8; // Link address skips the delay slot
            default:                   result_d = '0;
        endcase
    end

    assign ovf_d = (dec.op inside {OP_ADD, OP_ADDI} && add_o) || (dec.op == OP_SUB && sub_o);
    assign ill_d = dec.op == OP_ILLEGAL;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wb.valid <= 1'b0;
            wb.we    <= 1'b0;
            wb.ovf   <= 1'b0;
            wb.ill   <= 1'b0;
        end else begin
            wb.valid <= dec.valid;
            wb.we    <= dec.valid && !ovf_d && !ill_d && (dec.dest_sel != DEST_NONE);
            wb.ovf   <= dec.valid && ovf_d;
            wb.ill   <= dec.valid && ill_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (dec.valid) begin
            wb.result <= result_d;
            wb.dest   <= dec.dest;
        end
    end

    a_ovf_only_signed: assert property (@(posedge i_clk) disable iff (i_rst)
        wb.valid && wb.ovf |-> $past(dec.op inside {OP_ADD, OP_ADDI, OP_SUB})
            && wb.result[31] != $past(srca[31]));

endmodule

// File: mips_decode.sv
`timescale 1ns/100ps

module mips_decode
    import mips_exec_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst,
    input  logic        i_instr_valid,
    input  logic [31:0] i_instr,
    input  logic [31:0] i_pc,
    alu_op_if.decode    alu
);
    logic [31:0] instr_q;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [4:0]  rd_f;

    assign opcode    = instr_q[31:26];
    assign funct     = instr_q[5:0];
    assign rd_f      = instr_q[15:11];
    assign alu.rs    = instr_q[25:21];
    assign alu.rt    = instr_q[20:16];
    assign alu.shamt = instr_q[10:6];
    assign alu.imm16 = instr_q[15:0];

    always_ff @(posedge i_clk) begin
        if (i_rst)
            alu.valid <= 1'b0;
        else
            alu.valid <= i_instr_valid;
    end

    always_ff @(posedge i_clk) begin
        if (i_instr_valid) begin
            instr_q <= i_instr;
            alu.pc  <= i_pc;
        end
    end

    always_comb begin
        alu.op = OP_ILLEGAL;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h00: alu.op = OP_SLL;
                    6'h02: alu.op = OP_SRL;
                    6'h03: alu.op = OP_SRA;
                    6'h04: alu.op = OP_SLLV;
                    6'h06: alu.op = OP_SRLV;
                    6'h07: alu.op = OP_SRAV;
                    6'h09: alu.op = OP_JALR;
                    6'h20: alu.op = OP_ADD;
                    6'h21: alu.op = OP_ADDU;
                    6'h22: alu.op = OP_SUB;
                    6'h23: alu.op = OP_SUBU;
                    6'h24: alu.op = OP_AND;
                    6'h25: alu.op = OP_OR;
                    6'h26: alu.op = OP_XOR;
                    6'h27: alu.op = OP_NOR;
                    6'h2A: alu.op = OP_SLT;
                    6'h2B: alu.op = OP_SLTU;
                    default: alu.op = OP_ILLEGAL;
                endcase
            end
            6'h01: begin // REGIMM selects on the rt field
                if (alu.rt == 5'h10)
                    alu.op = OP_BLTZAL;
                else if (alu.rt == 5'h11)
                    alu.op = OP_BGEZAL;
            end
            6'h03: alu.op = OP_JAL;
            6'h08: alu.op = OP_ADDI;
            6'h09: alu.op = OP_ADDIU;
            6'h0A: alu.op = OP_SLTI;
            6'h0B: alu.op = OP_SLTIU;
            6'h0C: alu.op = OP_ANDI;
            6'h0D: alu.op = OP_ORI;
            6'h0E: alu.op = OP_XORI;
            6'h0F: alu.op = OP_LUI;
            6'h20: alu.op = OP_LB;
            6'h21: alu.op = OP_LH;
            6'h22: alu.op = OP_LWL;
            6'h23: alu.op = OP_LW;
            6'h24: alu.op = OP_LBU;
            6'h25: alu.op = OP_LHU;
            6'h26: alu.op = OP_LWR;
            6'h28: alu.op = OP_SB;
            6'h29: alu.op = OP_SH;
            6'h2A: alu.op = OP_SWL;
            6'h2B: alu.op = OP_SW;
            6'h2E: alu.op = OP_SWR;
            default: alu.op = OP_ILLEGAL;
        endcase
    end

    always_comb begin
        case (alu.op)
            OP_JAL, OP_BLTZAL, OP_BGEZAL:
                alu.dest_sel = DEST_R31;
            OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
                alu.dest_sel = DEST_RT;
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
            OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR, OP_ILLEGAL:
                alu.dest_sel = DEST_NONE; // Loads only form an address here
            default:
                alu.dest_sel = DEST_RD;
        endcase
    end

    always_comb begin
        case (alu.dest_sel)
            DEST_RT:  alu.dest = alu.rt;
            DEST_RD:  alu.dest = rd_f;
            DEST_R31: alu.dest = 5'd31;
            default:  alu.dest = 5'd0;
        endcase
    end

    a_op_known: assert property (@(posedge i_clk) disable iff (i_rst)
        alu.valid |-> !$isunknown(instr_q));

endmodule

// File: mips_apb_port.sv
`timescale 1ns/100ps

module mips_apb_port
    import mips_exec_pkg::*;
#(
    parameter int APB_ADDR_W = 12
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  logic                  i_psel,
    input  logic                  i_penable,
    input  logic                  i_pwrite,
    input  logic [APB_ADDR_W-1:0] i_paddr,
    input  logic [31:0]           i_pwdata,
    output logic [31:0]           o_prdata,
    output logic                  o_pready,
    output logic                  o_pslverr,
    output logic                  o_instr_valid,
    output logic [31:0]           o_instr,
    output logic [31:0]           o_pc,
    alu_op_if.monitor             dec,
    exec_wb_if.monitor            exe,
    host_if.host                  host
);
    localparam logic [APB_ADDR_W-1:0] GPR_IDX_MASK = APB_ADDR_W'(12'h07C);

    logic access;
    logic wr;
    logic is_gpr, is_instr, is_pc, is_result, is_status;
    logic bad;

    assign o_pready = !(o_instr_valid || dec.valid || exe.valid); // Wait states while in flight
    assign access   = i_psel && i_penable && o_pready;
    assign wr       = access && i_pwrite;

    assign is_gpr    = (i_paddr & ~GPR_IDX_MASK) == APB_ADDR_W'(REG_GPR_BASE);
    assign is_instr  = i_paddr == APB_ADDR_W'(REG_INSTR);
    assign is_pc     = i_paddr == APB_ADDR_W'(REG_PC);
    assign is_result = i_paddr == APB_ADDR_W'(REG_RESULT);
    assign is_status = i_paddr == APB_ADDR_W'(REG_STATUS);

    assign bad = !(is_gpr || is_instr || is_pc || is_result || is_status)
               || (i_pwrite && is_result) || (!i_pwrite && is_instr);
    assign o_pslverr = access && bad;

    assign host.gpr_addr = i_paddr[6:2];
    assign host.wdata    = i_pwdata;
    assign host.gpr_we   = wr && is_gpr;
    assign host.stat_clr = (wr && is_status) ? i_pwdata[1:0] : 2'b00;

    always_comb begin
        o_prdata = '0;
        if (is_gpr)
            o_prdata = host.gpr_rdata;
        else if (is_pc)
            o_prdata = o_pc;
        else if (is_result)
            o_prdata = host.result;
        else if (is_status)
            o_prdata = {30'b0, host.status};
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_instr_valid <= 1'b0;
            o_pc          <= '0;
        end else begin
            o_instr_valid <= wr && is_instr; // One-cycle strobe to decode
            if (wr && is_pc)
                o_pc <= i_pwdata;
        end
    end

    always_ff @(posedge i_clk) begin
        if (wr && is_instr)
            o_instr <= i_pwdata;
    end

    a_slverr_no_write: assert property (@(posedge i_clk) disable iff (i_rst)
        o_pslverr |-> !host.gpr_we && host.stat_clr == 2'b00);

    a_slverr_no_strobe: assert property (@(posedge i_clk) disable iff (i_rst)
        o_pslverr |=> !o_instr_valid && $stable(o_pc));

endmodule

// File: host_if.sv
`timescale 1ns/100ps

interface host_if ();
    logic [4:0]  gpr_addr;
    logic        gpr_we;
    logic [31:0] wdata;
    logic [1:0]  stat_clr; // Write-one-to-clear mask for STATUS
    logic [31:0] gpr_rdata;
    logic [31:0] result;
    logic [1:0]  status;

    modport host (output gpr_addr, gpr_we, wdata, stat_clr, input gpr_rdata, result, status);
    modport target (input gpr_addr, gpr_we, wdata, stat_clr, output gpr_rdata, result, status);

endinterface

// File: exec_wb_if.sv
`timescale 1ns/100ps

interface exec_wb_if ();
    logic        valid;
    logic [31:0] result;
    logic [4:0]  dest;
    logic        we;
    logic        ovf;
    logic        ill;
    logic [4:0]  rs_addr;
    logic [4:0]  rt_addr;
    logic [31:0] rs_data;
    logic [31:0] rt_data;

    modport execute (
        output valid, result, dest, we, ovf, ill, rs_addr, rt_addr,
        input  rs_data, rt_data
    );
    modport writeback (
        input  valid, result, dest, we, ovf, ill, rs_addr, rt_addr,
        output rs_data, rt_data
    );
    modport monitor (input valid);

endinterface

// File: alu_op_if.sv
`timescale 1ns/100ps

interface alu_op_if
    import mips_exec_pkg::*;
();
    logic        valid;
    alu_op_e     op;
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  dest;
    dest_sel_e   dest_sel;
    logic [15:0] imm16;
    logic [4:0]  shamt;
    logic [31:0] pc;

    modport decode (output valid, op, rs, rt, dest, dest_sel, imm16, shamt, pc);
    modport execute (input valid, op, rs, rt, dest, dest_sel, imm16, shamt, pc);
    modport monitor (input valid);

endinterface

// File: mips_exec_pkg.sv
package mips_exec_pkg;

    // One value per supported instruction kind
    typedef enum logic [5:0] {
        OP_ADD, OP_ADDU, OP_ADDI, OP_ADDIU, OP_SUB, OP_SUBU,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR, OP_LUI,
        OP_SLL, OP_SRL, OP_SRA, OP_SLLV, OP_SRLV, OP_SRAV,
        OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU,
        OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR,
        OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR,
        OP_ILLEGAL
    } alu_op_e;

    typedef enum logic [1:0] {
        DEST_NONE,
        DEST_RT,
        DEST_RD,
        DEST_R31
    } dest_sel_e;

    localparam logic [11:0] REG_GPR_BASE = 12'h000; // 32 words
    localparam logic [11:0] REG_INSTR    = 12'h080;
    localparam logic [11:0] REG_PC       = 12'h084;
    localparam logic [11:0] REG_RESULT   = 12'h088;
    localparam logic [11:0] REG_STATUS   = 12'h08C;

    localparam int STAT_OVF = 0; // Sticky signed overflow
    localparam int STAT_ILL = 1; // Sticky illegal opcode

endpackage
